// ==== logic/soc_pkg.sv ====
package soc_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int unsigned AddrWidth  = 64;
  localparam int unsigned DataWidth  = 64;
  localparam int unsigned StrbWidth  = DataWidth / 8;
  localparam int unsigned ByteOffset = $clog2(StrbWidth); // Bits dropped for the word index
  localparam int unsigned ExitWidth  = 32;                // Lower half of the written word
  localparam int unsigned NbHarts    = 2;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [ExitWidth-1:0] exit_t;
  typedef logic [NbHarts-1:0]   hart_vec_t;

  // Decoded target of a request
  typedef enum logic [1:0] {
    TgtRom  = 2'd0,
    TgtDram = 2'd1,
    TgtErr  = 2'd2
  } target_e;

  // --------------------------------------------------
  // Address map
  // --------------------------------------------------
  localparam addr_t RomBase    = 64'h0000_0000_0001_0000;
  localparam addr_t RomLength  = 64'h0000_0000_0001_0000;
  localparam addr_t GpioBase   = 64'h0000_0000_4000_0000; // Served by the error target
  localparam addr_t GpioLength = 64'h0000_0000_0000_1000;
  localparam addr_t DramBase   = 64'h0000_0000_8000_0000; // Length set by NumWords
  localparam addr_t ExitAddr   = DramBase;

  // Boot ROM contents
  localparam int unsigned RomWords    = 16;
  localparam int unsigned RomIdxWidth = $clog2(RomWords);
  localparam logic [31:0] RomTag      = 32'hB007_10AD;

  // Error target read pattern
  localparam data_t ErrData = 64'hDEAD_BEEF_DEAD_BEEF;

  // Tag in the upper half, word index in the lower half
  function automatic data_t rom_word(input logic [RomIdxWidth-1:0] idx);
    data_t word;
    word = {RomTag, {(32 - RomIdxWidth){1'b0}}, idx};
    return word;
  endfunction

endpackage

// ==== logic/addr_decode_stage.sv ====
`timescale 1ns/10ps

module addr_decode_stage #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_valid_i,
  input  logic                          req_we_i,
  input  soc_pkg::addr_t                req_addr_i,
  input  soc_pkg::strb_t                req_be_i,
  input  soc_pkg::data_t                req_wdata_i,
  output logic                          dec_valid_o,
  output logic                          dec_we_o,
  output soc_pkg::target_e              dec_target_o,
  output logic [$clog2(NumWords)-1:0]   dec_index_o,
  output soc_pkg::strb_t                dec_be_o,
  output soc_pkg::data_t                dec_wdata_o,
  output logic                          dec_exit_o
);

  localparam int unsigned IdxWidth = $clog2(NumWords);
  localparam soc_pkg::addr_t DramLength =
    soc_pkg::addr_t'(NumWords) * soc_pkg::addr_t'(soc_pkg::StrbWidth);

  // Request capture
  logic           req_valid_q;
  logic           req_we_q;
  soc_pkg::addr_t req_addr_q;
  soc_pkg::strb_t req_be_q;
  soc_pkg::data_t req_wdata_q;

  logic             in_rom, in_dram;
  soc_pkg::target_e target;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    req_we_q    <= req_we_i;
    req_addr_q  <= req_addr_i;
    req_be_q    <= req_be_i;
    req_wdata_q <= req_wdata_i;
  end

  // --------------------------------------------------
  // Address map lookup
  // --------------------------------------------------
  assign in_rom  = (req_addr_q >= soc_pkg::RomBase) &&
                   (req_addr_q < soc_pkg::RomBase + soc_pkg::RomLength);
  assign in_dram = (req_addr_q >= soc_pkg::DramBase) &&
                   (req_addr_q < soc_pkg::DramBase + DramLength);

  always_comb begin
    if (in_rom && !req_we_q) begin
      target = soc_pkg::TgtRom;
    end else if (in_dram) begin
      target = soc_pkg::TgtDram;
    end else begin
      target = soc_pkg::TgtErr; // GPIO, unmapped and ROM writes
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= req_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    dec_we_o     <= req_we_q;
    dec_target_o <= target;
    // Windows are aligned so the low address bits are the relative index
    dec_index_o  <= req_addr_q[IdxWidth+soc_pkg::ByteOffset-1:soc_pkg::ByteOffset];
    dec_be_o     <= req_be_q;
    dec_wdata_o  <= req_wdata_q;
    dec_exit_o   <= req_we_q && in_dram && (req_addr_q == soc_pkg::ExitAddr);
  end

endmodule

// ==== logic/mem_access_stage.sv ====
`timescale 1ns/10ps

module mem_access_stage #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          dec_valid_i,
  input  logic                          dec_we_i,
  input  soc_pkg::target_e              dec_target_i,
  input  logic [$clog2(NumWords)-1:0]   dec_index_i,
  input  soc_pkg::strb_t                dec_be_i,
  input  soc_pkg::data_t                dec_wdata_i,
  input  logic                          dec_exit_i,
  output logic                          acc_valid_o,
  output logic                          acc_we_o,
  output soc_pkg::data_t                acc_rdata_o,
  output logic                          acc_err_o,
  output logic                          acc_exit_o,
  output soc_pkg::exit_t                acc_exit_val_o
);

  // --------------------------------------------------
  // DRAM array
  // --------------------------------------------------
  soc_pkg::data_t dram_q [NumWords];

  logic           dram_we;
  soc_pkg::data_t dram_rdata;
  soc_pkg::data_t rom_rdata;
  soc_pkg::data_t rdata;
  logic           err;

  assign dram_we = dec_valid_i && dec_we_i && (dec_target_i == soc_pkg::TgtDram);

  // Byte-enabled write, one word per cycle
  always_ff @(posedge clk_i) begin
    if (dram_we) begin
      for (int b = 0; b < soc_pkg::StrbWidth; b++) begin
        if (dec_be_i[b]) begin
          dram_q[dec_index_i][b*8 +: 8] <= dec_wdata_i[b*8 +: 8];
        end
      end
    end
  end

  assign dram_rdata = dram_q[dec_index_i];

  // --------------------------------------------------
  // Boot ROM
  // --------------------------------------------------
  // Only the low index bits matter, so the 16 words repeat over the window
  assign rom_rdata = soc_pkg::rom_word(dec_index_i[soc_pkg::RomIdxWidth-1:0]);

  // Target select, error target answers everything else
  always_comb begin
    case (dec_target_i)
      soc_pkg::TgtRom: begin
        rdata = rom_rdata;
        err   = 1'b0;
      end
      soc_pkg::TgtDram: begin
        rdata = dram_rdata;
        err   = 1'b0;
      end
      default: begin
        rdata = soc_pkg::ErrData;
        err   = 1'b1;
      end
    endcase
  end

  // --------------------------------------------------
  // Output registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_valid_o <= 1'b0;
      acc_we_o    <= 1'b0;
      acc_err_o   <= 1'b0;
      acc_exit_o  <= 1'b0;
    end else begin
      acc_valid_o <= dec_valid_i;
      acc_we_o    <= dec_we_i;
      acc_err_o   <= dec_valid_i && err;
      acc_exit_o  <= dec_valid_i && dec_exit_i; // Decode already checked target and write
    end
  end

  always_ff @(posedge clk_i) begin
    acc_rdata_o    <= rdata;
    acc_exit_val_o <= dec_wdata_i[soc_pkg::ExitWidth-1:0];
  end

endmodule

// ==== logic/resp_stage.sv ====
`timescale 1ns/10ps

module resp_stage (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           acc_valid_i,
  input  logic           acc_we_i,
  input  soc_pkg::data_t acc_rdata_i,
  input  logic           acc_err_i,
  input  logic           acc_exit_i,
  input  soc_pkg::exit_t acc_exit_val_i,
  output logic           rsp_valid_o,
  output soc_pkg::data_t rsp_rdata_o,
  output logic           rsp_err_o,
  output soc_pkg::exit_t exit_o
);

  logic           write_ok;
  soc_pkg::data_t rdata;
  soc_pkg::exit_t exit_val;

  // Clean writes answer with zero data
  assign write_ok = acc_we_i && !acc_err_i;
  assign rdata    = write_ok ? '0 : acc_rdata_i;

  assign exit_val = (acc_valid_i && acc_exit_i) ? acc_exit_val_i : '0;

  // --------------------------------------------------
  // Response registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_o <= 1'b0;
      rsp_err_o   <= 1'b0;
      exit_o      <= '0;
    end else begin
      rsp_valid_o <= acc_valid_i;
      rsp_err_o   <= acc_valid_i && acc_err_i;
      exit_o      <= exit_val; // Nonzero only in the exit response cycle
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_rdata_o <= rdata;
  end

endmodule

// ==== logic/debug_gate.sv ====
`timescale 1ns/10ps

module debug_gate #(
  parameter int unsigned DbgDelayCycles = 500
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  soc_pkg::hart_vec_t debug_req_i,
  input  logic               debug_en_i,
  output soc_pkg::hart_vec_t debug_req_o
);

  localparam int unsigned CntWidth = (DbgDelayCycles > 0) ? $clog2(DbgDelayCycles + 1) : 1;

  // Hold-off counter, gives boot code time before any debug request lands
  logic [CntWidth-1:0] delay_cnt_q;
  logic                holdoff;

  assign holdoff = (delay_cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      delay_cnt_q <= CntWidth'(DbgDelayCycles);
    end else if (holdoff) begin
      delay_cnt_q <= delay_cnt_q - 1'b1; // Stops at zero
    end
  end

  // --------------------------------------------------
  // Request gating
  // --------------------------------------------------
  always_comb begin
    if (holdoff || !debug_en_i) begin
      debug_req_o = '0;
    end else begin
      debug_req_o = debug_req_i;
    end
  end

endmodule

// ==== logic/culsans_top.sv ====
`timescale 1ns/10ps

module culsans_top #(
  parameter int unsigned NumWords       = 1024,
  parameter int unsigned DbgDelayCycles = 500
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_valid_i,
  input  logic               req_we_i,
  input  soc_pkg::addr_t     req_addr_i,
  input  soc_pkg::strb_t     req_be_i,
  input  soc_pkg::data_t     req_wdata_i,
  output logic               rsp_valid_o,
  output soc_pkg::data_t     rsp_rdata_o,
  output logic               rsp_err_o,
  output soc_pkg::exit_t     exit_o,
  input  soc_pkg::hart_vec_t debug_req_i,
  input  logic               debug_en_i,
  output soc_pkg::hart_vec_t debug_req_o
);

  localparam int unsigned IdxWidth = $clog2(NumWords);

  // Decode to access
  logic                  dec_valid;
  logic                  dec_we;
  soc_pkg::target_e      dec_target;
  logic [IdxWidth-1:0]   dec_index;
  soc_pkg::strb_t        dec_be;
  soc_pkg::data_t        dec_wdata;
  logic                  dec_exit;

  // Access to response
  logic                  acc_valid;
  logic                  acc_we;
  soc_pkg::data_t        acc_rdata;
  logic                  acc_err;
  logic                  acc_exit;
  soc_pkg::exit_t        acc_exit_val;

  // --------------------------------------------------
  // Request pipeline
  // --------------------------------------------------
  addr_decode_stage #(
    .NumWords ( NumWords )
  ) i_addr_decode_stage (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_valid_i  ( req_valid_i  ),
    .req_we_i     ( req_we_i     ),
    .req_addr_i   ( req_addr_i   ),
    .req_be_i     ( req_be_i     ),
    .req_wdata_i  ( req_wdata_i  ),
    .dec_valid_o  ( dec_valid    ),
    .dec_we_o     ( dec_we       ),
    .dec_target_o ( dec_target   ),
    .dec_index_o  ( dec_index    ),
    .dec_be_o     ( dec_be       ),
    .dec_wdata_o  ( dec_wdata    ),
    .dec_exit_o   ( dec_exit     )
  );

  mem_access_stage #(
    .NumWords ( NumWords )
  ) i_mem_access_stage (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .dec_valid_i    ( dec_valid    ),
    .dec_we_i       ( dec_we       ),
    .dec_target_i   ( dec_target   ),
    .dec_index_i    ( dec_index    ),
    .dec_be_i       ( dec_be       ),
    .dec_wdata_i    ( dec_wdata    ),
    .dec_exit_i     ( dec_exit     ),
    .acc_valid_o    ( acc_valid    ),
    .acc_we_o       ( acc_we       ),
    .acc_rdata_o    ( acc_rdata    ),
    .acc_err_o      ( acc_err      ),
    .acc_exit_o     ( acc_exit     ),
    .acc_exit_val_o ( acc_exit_val )
  );

  resp_stage i_resp_stage (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .acc_valid_i    ( acc_valid    ),
    .acc_we_i       ( acc_we       ),
    .acc_rdata_i    ( acc_rdata    ),
    .acc_err_i      ( acc_err      ),
    .acc_exit_i     ( acc_exit     ),
    .acc_exit_val_i ( acc_exit_val ),
    .rsp_valid_o    ( rsp_valid_o  ),
    .rsp_rdata_o    ( rsp_rdata_o  ),
    .rsp_err_o      ( rsp_err_o    ),
    .exit_o         ( exit_o       )
  );

  // Debug requests, independent of the memory path
  debug_gate #(
    .DbgDelayCycles ( DbgDelayCycles )
  ) i_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// ==== verif/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------------------------------------
// Compare tasks, one per result kind
// --------------------------------------------------
task automatic check_data(input string name, input soc_pkg::data_t got,
                          input soc_pkg::data_t exp);
  if (got !== exp) begin
    $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    fail_run();
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    fail_run();
  end
endtask

task automatic check_exit(input string name, input soc_pkg::exit_t got,
                          input soc_pkg::exit_t exp);
  if (got !== exp) begin
    $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    fail_run();
  end
endtask

// Per-hart request vector
task automatic check_harts(input string name, input soc_pkg::hart_vec_t got,
                           input soc_pkg::hart_vec_t exp);
  if (got !== exp) begin
    $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    fail_run();
  end
endtask

`endif

// ==== verif/culsans_top_tb.sv ====
`timescale 1ns/10ps

module culsans_top_tb;

  localparam int unsigned ClkPeriod   = 100;
  localparam int unsigned DriveDelay  = 10;
  localparam int unsigned ResetCycles = 8;
  localparam int unsigned Latency     = 3;
  localparam int unsigned Margin      = 4;
  localparam int unsigned NumRows     = 17;
  localparam int unsigned RandWords   = 16;  // DRAM words 1..16, word 0 is the exit address
  localparam int unsigned NumRandom   = 200;
  localparam int unsigned DbgCycles   = 48;  // Hold-off checks, settle and enable combos
  localparam int unsigned Seed        = 98931;
  localparam int unsigned WatchdogCycles = ResetCycles + DbgCycles +
    (NumRows + RandWords + NumRandom) * (Latency + Margin);

  logic clk_i, rst_ni, req_valid_i, req_we_i, debug_en_i;
  soc_pkg::addr_t     req_addr_i;
  soc_pkg::strb_t     req_be_i;
  soc_pkg::data_t     req_wdata_i, rsp_rdata_o;
  logic               rsp_valid_o, rsp_err_o;
  soc_pkg::exit_t     exit_o;
  soc_pkg::hart_vec_t debug_req_i, debug_req_o;

  typedef struct packed {
    logic           we;
    soc_pkg::addr_t addr;
    soc_pkg::strb_t be;
    soc_pkg::data_t wdata;
    soc_pkg::data_t rdata;
    logic           err;
    soc_pkg::exit_t exit_val;
  } row_t;

  row_t           rows [NumRows];
  int unsigned    row_cnt;
  soc_pkg::data_t ref_mem [RandWords+1];
  int unsigned    cycle_cnt;
  logic           monitor_on;

  // Outstanding responses, in issue order
  soc_pkg::data_t exp_rdata_q [$];
  logic           exp_err_q [$];
  soc_pkg::exit_t exp_exit_q [$];
  int unsigned    exp_due_q [$];

  culsans_top #(
    .NumWords       ( 1024 ),
    .DbgDelayCycles ( 16   )
  ) dut (
    .clk_i, .rst_ni, .req_valid_i, .req_we_i, .req_addr_i, .req_be_i, .req_wdata_i,
    .rsp_valid_o, .rsp_rdata_o, .rsp_err_o, .exit_o, .debug_req_i, .debug_en_i, .debug_req_o
  );

  task automatic fail_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "Run stopped at the first error");
  endtask

  `include "tb_checks.svh"

  task automatic add_row(input logic we, input soc_pkg::addr_t addr, input soc_pkg::strb_t be,
                         input soc_pkg::data_t wdata, input soc_pkg::data_t rdata,
                         input logic err, input soc_pkg::exit_t exit_val);
    rows[row_cnt] = {we, addr, be, wdata, rdata, err, exit_val};
    row_cnt++;
  endtask

  // --------------------------------------------------
  // Directed table: ROM, error target, DRAM, exit
  // --------------------------------------------------
  task automatic load_table();
    row_cnt = 0;
    add_row(1'b0, 64'h0001_0000, 8'hFF, '0, 64'hB007_10AD_0000_0000, 1'b0, '0);
    add_row(1'b0, 64'h0001_0028, 8'hFF, '0, 64'hB007_10AD_0000_0005, 1'b0, '0);
    add_row(1'b0, 64'h0001_0078, 8'hFF, '0, 64'hB007_10AD_0000_000F, 1'b0, '0);
    add_row(1'b0, 64'h0001_0080, 8'hFF, '0, 64'hB007_10AD_0000_0000, 1'b0, '0); // Wraps
    add_row(1'b1, 64'h0001_0008, 8'hFF, 64'h1234, 64'hDEAD_BEEF_DEAD_BEEF, 1'b1, '0);
    add_row(1'b0, 64'h4000_0000, 8'hFF, '0, 64'hDEAD_BEEF_DEAD_BEEF, 1'b1, '0);   // GPIO
    add_row(1'b1, 64'h4000_0FF8, 8'hFF, 64'h55, 64'hDEAD_BEEF_DEAD_BEEF, 1'b1, '0);
    add_row(1'b0, 64'h0000_1000, 8'hFF, '0, 64'hDEAD_BEEF_DEAD_BEEF, 1'b1, '0);   // Unmapped
    add_row(1'b1, 64'h2000_0000, 8'h0F, 64'h77, 64'hDEAD_BEEF_DEAD_BEEF, 1'b1, '0);
    add_row(1'b0, 64'h8000_2000, 8'hFF, '0, 64'hDEAD_BEEF_DEAD_BEEF, 1'b1, '0);   // Past DRAM
    add_row(1'b1, 64'h8000_0010, 8'hFF, 64'h0123_4567_89AB_CDEF, '0, 1'b0, '0);
    add_row(1'b1, 64'h8000_0010, 8'hA5, 64'hFFEE_DDCC_BBAA_9988, '0, 1'b0, '0);
    add_row(1'b0, 64'h8000_0010, 8'hFF, '0, 64'hFF23_DD67_89AA_CD88, 1'b0, '0);   // Merged
    add_row(1'b1, 64'h8000_1FF8, 8'hFF, 64'h5555_AAAA_0F0F_F0F0, '0, 1'b0, '0);
    add_row(1'b0, 64'h8000_1FF8, 8'hFF, '0, 64'h5555_AAAA_0F0F_F0F0, 1'b0, '0);
    add_row(1'b1, 64'h8000_0000, 8'hFF, 64'h1111_2222_CAFE_F00D, '0, 1'b0, 32'hCAFE_F00D);
    add_row(1'b0, 64'h8000_0000, 8'hFF, '0, 64'h1111_2222_CAFE_F00D, 1'b0, '0);
  endtask

  function automatic soc_pkg::data_t merge_bytes(input soc_pkg::data_t old_word,
                                                 input soc_pkg::data_t new_word,
                                                 input soc_pkg::strb_t be);
    soc_pkg::data_t word;
    word = old_word;
    for (int b = 0; b < soc_pkg::StrbWidth; b++) begin
      if (be[b]) word[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return word;
  endfunction

  // Drive one request, queue its expected response, move to the next slot
  task automatic issue(input logic we, input soc_pkg::addr_t addr, input soc_pkg::strb_t be,
                       input soc_pkg::data_t wdata, input soc_pkg::data_t exp_rdata,
                       input logic exp_err, input soc_pkg::exit_t exp_exit);
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_be_i    = be;
    req_wdata_i = wdata;
    exp_rdata_q.push_back(exp_rdata);
    exp_err_q.push_back(exp_err);
    exp_exit_q.push_back(exp_exit);
    exp_due_q.push_back(cycle_cnt + 1 + Latency); // Sampled on the next edge
    @(posedge clk_i);
    #DriveDelay;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // --------------------------------------------------
  // Response monitor, samples mid-cycle
  // --------------------------------------------------
  always @(negedge clk_i) begin : rsp_monitor
    soc_pkg::data_t exp_rdata;
    logic           exp_err;
    soc_pkg::exit_t exp_exit;
    if (monitor_on && rsp_valid_o) begin
      if (exp_due_q.size() == 0) begin
        $display("ERROR: response in cycle %0d with no request outstanding", cycle_cnt);
        fail_run();
      end else if (exp_due_q[0] != cycle_cnt) begin
        $display("ERROR: response in cycle %0d, expected in cycle %0d", cycle_cnt,
                 exp_due_q[0]);
        fail_run();
      end else begin
        exp_rdata = exp_rdata_q.pop_front();
        exp_err   = exp_err_q.pop_front();
        exp_exit  = exp_exit_q.pop_front();
        void'(exp_due_q.pop_front());
        check_data("rsp_rdata_o", rsp_rdata_o, exp_rdata);
        check_flag("rsp_err_o", rsp_err_o, exp_err);
        check_exit("exit_o", exit_o, exp_exit);
      end
    end else if (monitor_on) begin
      if (exp_due_q.size() != 0 && exp_due_q[0] <= cycle_cnt) begin
        $display("ERROR: no response in cycle %0d for a request due then", exp_due_q[0]);
        fail_run();
      end
      check_exit("exit_o", exit_o, '0); // Idle cycles keep exit_o clear
    end
  end

  initial begin : watchdog
    #(WatchdogCycles * ClkPeriod);
    $display("ERROR: timeout, the run did not finish within %0d cycles", WatchdogCycles);
    fail_run();
  end

  initial begin : main_seq
    soc_pkg::data_t wdata;
    soc_pkg::strb_t be;
    logic           we;
    int unsigned    idx;
    int unsigned    reset_cycle;
    void'($urandom(Seed));
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_be_i    = '0;
    req_wdata_i = '0;
    debug_req_i = '1;   // Requests pending straight out of reset
    debug_en_i  = 1'b1;
    cycle_cnt   = 0;
    monitor_on  = 1'b0;
    load_table();
    repeat (ResetCycles) @(posedge clk_i);
    #DriveDelay;
    rst_ni      = 1'b1;
    reset_cycle = cycle_cnt;
    monitor_on  = 1'b1;

    // Debug hold-off window, then enable gating
    for (int i = 0; i < 8; i++) begin
      debug_req_i = soc_pkg::hart_vec_t'(i % 3 + 1);
      @(negedge clk_i);
      check_harts("debug_req_o", debug_req_o, '0);
      @(posedge clk_i);
      #DriveDelay;
    end
    while (cycle_cnt < reset_cycle + 30) begin
      @(posedge clk_i);
      #DriveDelay;
    end
    for (int c = 0; c < 8; c++) begin
      debug_en_i  = (c >= 4);
      debug_req_i = soc_pkg::hart_vec_t'(c % 4);
      @(negedge clk_i);
      check_harts("debug_req_o", debug_req_o, (c >= 4) ? soc_pkg::hart_vec_t'(c % 4) : '0);
      @(posedge clk_i);
      #DriveDelay;
    end
    debug_en_i  = 1'b0;
    debug_req_i = '0;

    for (int r = 0; r < NumRows; r++) begin
      issue(rows[r].we, rows[r].addr, rows[r].be, rows[r].wdata, rows[r].rdata, rows[r].err,
            rows[r].exit_val);
    end

    // Random phase, preload so every read has a known value
    for (int w = 1; w <= RandWords; w++) begin
      wdata      = {$urandom, $urandom};
      ref_mem[w] = wdata;
      issue(1'b1, soc_pkg::DramBase + w * 8, '1, wdata, '0, 1'b0, '0);
    end
    for (int n = 0; n < NumRandom; n++) begin
      idx   = 1 + $urandom % RandWords;
      we    = $urandom % 2;
      be    = soc_pkg::strb_t'($urandom);
      wdata = {$urandom, $urandom};
      if (we) begin
        ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, be);
        issue(1'b1, soc_pkg::DramBase + idx * 8, be, wdata, '0, 1'b0, '0);
      end else begin
        issue(1'b0, soc_pkg::DramBase + idx * 8, be, wdata, ref_mem[idx], 1'b0, '0);
      end
    end
    req_valid_i = 1'b0;

    while (exp_due_q.size() != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== culsans_top.f ====
+incdir+verif
logic/soc_pkg.sv
logic/addr_decode_stage.sv
logic/mem_access_stage.sv
logic/resp_stage.sv
logic/debug_gate.sv
logic/culsans_top.sv
verif/culsans_top_tb.sv
